//--- common/motor_pkg.sv
`default_nettype none

package motor_pkg;

    typedef enum logic [1:0] {
        drive_run       = 2'd0,
        drive_calibrate = 2'd1, // lead forced to zero, used to find the offset
        drive_test      = 2'd2  // indices follow offset only
    } drive_mode_e;

    localparam int table_len      = 64;
    localparam int angle_w        = 6;
    localparam int lead_angle     = 16; // quarter period
    localparam int phase_v_offset = 21;
    localparam int phase_w_offset = 42;
    localparam int volt_max       = 100; // percent of full voltage

    // one electrical period, offset so that the midpoint is 127
    localparam logic [7:0] sine_tbl [table_len] = '{
        8'd127, 8'd139, 8'd151, 8'd163, 8'd175, 8'd186, 8'd197, 8'd207,
        8'd216, 8'd225, 8'd232, 8'd239, 8'd244, 8'd248, 8'd251, 8'd253,
        8'd255, 8'd253, 8'd251, 8'd248, 8'd244, 8'd239, 8'd232, 8'd225,
        8'd216, 8'd207, 8'd197, 8'd186, 8'd175, 8'd163, 8'd151, 8'd139,
        8'd127, 8'd114, 8'd102, 8'd90,  8'd78,  8'd67,  8'd56,  8'd46,
        8'd37,  8'd28,  8'd21,  8'd14,  8'd9,   8'd5,   8'd2,   8'd0,
        8'd0,   8'd0,   8'd2,   8'd5,   8'd9,   8'd14,  8'd21,  8'd28,
        8'd37,  8'd46,  8'd56,  8'd67,  8'd78,  8'd90,  8'd102, 8'd114
    };

    function automatic logic [7:0] sine_value(input logic [angle_w-1:0] idx);
        return sine_tbl[idx];
    endfunction

endpackage

`default_nettype wire

//--- common/pwm_pkg.sv
`default_nettype none

package pwm_pkg;

    // gate pattern selection for the output stage
    typedef enum logic [1:0] {
        pwm_complementary  = 2'd0, // high and low side driven as a pair
        pwm_block_low      = 2'd1, // pwm high side, static low side
        pwm_block_switched = 2'd2, // both sides modulated in their regions
        pwm_block_sync     = 2'd3  // synchronous rectification in upper region
    } pwm_mode_e;

    localparam int duty_w = 8;

endpackage

`default_nettype wire

//--- commutation/phase_angle.sv
`timescale 1ns/1ns
`default_nettype none

module phase_angle #(
    parameter int fb_shift = 4
) (
    input  wire                                 clk,
    input  wire                                 arst_n,
    input  wire motor_pkg::drive_mode_e         mode,
    input  wire signed [15:0]                   velocity,
    input  wire signed [7:0]                    offset,
    input  wire [15:0]                          feedback,
    output logic [motor_pkg::angle_w-1:0]       idx_u,
    output logic [motor_pkg::angle_w-1:0]       idx_v,
    output logic [motor_pkg::angle_w-1:0]       idx_w,
    output logic [7:0]                          volt
);

    logic [motor_pkg::angle_w-1:0] fb_idx;
    logic [motor_pkg::angle_w-1:0] off_idx;
    logic [motor_pkg::angle_w-1:0] lead;
    logic [motor_pkg::angle_w-1:0] base_idx;
    logic [15:0]                   vel_mag;
    logic [7:0]                    volt_clip;

    assign fb_idx  = motor_pkg::angle_w'(feedback >> fb_shift);
    assign off_idx = offset[motor_pkg::angle_w-1:0]; // low bits wrap modulo the table

    always_comb begin
        if (mode == motor_pkg::drive_calibrate || velocity == 16'sd0) begin
            lead = '0;
        end else if (velocity > 16'sd0) begin
            lead = motor_pkg::angle_w'(motor_pkg::lead_angle);
        end else begin
            lead = motor_pkg::angle_w'(-motor_pkg::lead_angle);
        end
    end

    // test mode ignores the rotor position
    assign base_idx = (mode == motor_pkg::drive_test) ? off_idx
                                                      : fb_idx + off_idx + lead;

    assign vel_mag   = velocity[15] ? 16'(-velocity) : 16'(velocity);
    assign volt_clip = (vel_mag > 16'(motor_pkg::volt_max)) ? 8'(motor_pkg::volt_max)
                                                            : vel_mag[7:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idx_u <= '0;
            idx_v <= '0;
            idx_w <= '0;
            volt  <= '0;
        end else begin
            idx_u <= base_idx;
            idx_v <= base_idx + motor_pkg::angle_w'(motor_pkg::phase_v_offset);
            idx_w <= base_idx + motor_pkg::angle_w'(motor_pkg::phase_w_offset);
            volt  <= volt_clip;
        end
    end

endmodule

`default_nettype wire

//--- commutation/duty_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module duty_sequencer (
    input  wire                              clk,
    input  wire                              arst_n,
    input  wire [motor_pkg::angle_w-1:0]     idx_u,
    input  wire [motor_pkg::angle_w-1:0]     idx_v,
    input  wire [motor_pkg::angle_w-1:0]     idx_w,
    input  wire [7:0]                        volt,
    input  wire [15:0]                       mul_prod,
    input  wire                              mul_ack,
    output logic [7:0]                       mul_a,
    output logic [7:0]                       mul_b,
    output logic                             mul_req,
    output logic [pwm_pkg::duty_w-1:0]       duty_u,
    output logic [pwm_pkg::duty_w-1:0]       duty_v,
    output logic [pwm_pkg::duty_w-1:0]       duty_w,
    output logic                             duty_strobe
);

    localparam logic [1:0] hs_request = 2'd0;
    localparam logic [1:0] hs_wait    = 2'd1;
    localparam logic [1:0] hs_release = 2'd2;

    localparam logic [1:0] sel_u = 2'd0;
    localparam logic [1:0] sel_v = 2'd1;
    localparam logic [1:0] sel_w = 2'd2;

    logic [1:0]                    hs_state;
    logic [1:0]                    sel;
    logic [motor_pkg::angle_w-1:0] cur_idx;
    logic [pwm_pkg::duty_w-1:0]    quot;

    always_comb begin
        case (sel)
            sel_u:   cur_idx = idx_u;
            sel_v:   cur_idx = idx_v;
            default: cur_idx = idx_w;
        endcase
    end

    // sine * percent / 100, at most 255
    assign quot = pwm_pkg::duty_w'(mul_prod / 16'd100);

    // operands settle on the same edge that raises req
    always_ff @(posedge clk) begin
        if (hs_state == hs_request) begin
            mul_a <= motor_pkg::sine_value(cur_idx);
            mul_b <= volt;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hs_state    <= hs_request;
            sel         <= sel_u;
            mul_req     <= 1'b0;
            duty_u      <= '0;
            duty_v      <= '0;
            duty_w      <= '0;
            duty_strobe <= 1'b0;
        end else begin
            duty_strobe <= 1'b0;
            case (hs_state)
                hs_request: begin
                    mul_req  <= 1'b1;
                    hs_state <= hs_wait;
                end
                hs_wait: begin
                    if (mul_ack) begin
                        mul_req  <= 1'b0;
                        hs_state <= hs_release;
                        case (sel)
                            sel_u: begin
                                duty_u <= quot;
                                sel    <= sel_v;
                            end
                            sel_v: begin
                                duty_v <= quot;
                                sel    <= sel_w;
                            end
                            default: begin
                                duty_w      <= quot;
                                duty_strobe <= 1'b1; // round complete
                                sel         <= sel_u;
                            end
                        endcase
                    end
                end
                hs_release: begin
                    if (!mul_ack) hs_state <= hs_request; // ack gone, next phase may start
                end
                default: hs_state <= hs_request;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/shift_add_multiplier.sv
`timescale 1ns/1ns
`default_nettype none

module shift_add_multiplier (
    input  wire         clk,
    input  wire         arst_n,
    input  wire [7:0]   a,
    input  wire [7:0]   b,
    input  wire         req,
    output logic [15:0] prod,
    output logic        ack
);

    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_shift   = 2'd1;
    localparam logic [1:0] st_present = 2'd2;
    localparam logic [1:0] st_hold    = 2'd3;

    logic [1:0]  state;
    logic [2:0]  bit_cnt;
    logic [7:0]  a_sh;
    logic [15:0] b_sh;
    logic [15:0] acc;

    // datapath, one bit of a per clock
    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            a_sh <= a;
            b_sh <= {8'd0, b};
            acc  <= '0;
        end else if (state == st_shift) begin
            if (a_sh[0]) acc <= acc + b_sh;
            a_sh <= a_sh >> 1;
            b_sh <= b_sh << 1;
        end
        if (state == st_present) prod <= acc;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= st_idle;
            bit_cnt <= '0;
            ack     <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    bit_cnt <= '0;
                    if (req) state <= st_shift;
                end
                st_shift: begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) state <= st_present; // eight partial products done
                end
                st_present: begin
                    ack   <= 1'b1;
                    state <= st_hold;
                end
                default: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- pwm/pwm_modulator.sv
`timescale 1ns/1ns
`default_nettype none

module pwm_modulator #(
    parameter int carrier_div = 9
) (
    input  wire                            clk,
    input  wire                            arst_n,
    input  wire [pwm_pkg::duty_w-1:0]      duty_u,
    input  wire [pwm_pkg::duty_w-1:0]      duty_v,
    input  wire [pwm_pkg::duty_w-1:0]      duty_w,
    output logic                           ph_u,
    output logic                           ph_v,
    output logic                           ph_w
);

    localparam int presc_w = (carrier_div > 0) ? $clog2(carrier_div + 1) : 1;
    localparam logic [pwm_pkg::duty_w-1:0] carrier_top = 254; // 255 steps per period

    logic [presc_w-1:0]         presc;
    logic                       tick;
    logic [pwm_pkg::duty_w-1:0] carrier;

    assign tick = (presc == presc_w'(carrier_div));

    // clock enable for the carrier, no derived clock
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            presc <= '0;
        end else if (tick) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            carrier <= '0;
        end else if (tick) begin
            carrier <= (carrier == carrier_top) ? '0 : carrier + 1'b1;
        end
    end

    // duty 0 never beats the counter, duty 255 always does
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ph_u <= 1'b0;
            ph_v <= 1'b0;
            ph_w <= 1'b0;
        end else begin
            ph_u <= (carrier < duty_u);
            ph_v <= (carrier < duty_v);
            ph_w <= (carrier < duty_w);
        end
    end

endmodule

`default_nettype wire

//--- pwm/gate_driver.sv
`timescale 1ns/1ns
`default_nettype none

module gate_driver #(
    parameter pwm_pkg::pwm_mode_e gate_mode = pwm_pkg::pwm_complementary
) (
    input  wire                          enable,
    input  wire                          ph_u,
    input  wire                          ph_v,
    input  wire                          ph_w,
    input  wire [motor_pkg::angle_w-1:0] idx_u,
    input  wire [motor_pkg::angle_w-1:0] idx_v,
    input  wire [motor_pkg::angle_w-1:0] idx_w,
    output logic                         u_p,
    output logic                         v_p,
    output logic                         w_p,
    output logic                         u_n,
    output logic                         v_n,
    output logic                         w_n
);

    localparam logic [7:0] upper_min = 8'd195;
    localparam logic [7:0] lower_max = 8'd65;

    logic [2:0] ph;
    logic [2:0] upper;
    logic [2:0] lower;
    logic [2:0] hi_side;
    logic [2:0] lo_side;

    // bit order is w, v, u
    assign ph    = {ph_w, ph_v, ph_u};
    assign upper = {motor_pkg::sine_value(idx_w) > upper_min,
                    motor_pkg::sine_value(idx_v) > upper_min,
                    motor_pkg::sine_value(idx_u) > upper_min};
    assign lower = {motor_pkg::sine_value(idx_w) < lower_max,
                    motor_pkg::sine_value(idx_v) < lower_max,
                    motor_pkg::sine_value(idx_u) < lower_max};

    always_comb begin
        case (gate_mode)
            pwm_pkg::pwm_block_low: begin
                hi_side = ph & upper;
                lo_side = lower;
            end
            pwm_pkg::pwm_block_switched: begin
                hi_side = ph & upper;
                lo_side = ~ph & lower;
            end
            pwm_pkg::pwm_block_sync: begin
                hi_side = ph & upper;
                lo_side = lower | (~ph & upper); // low side conducts in the off time
            end
            default: begin
                hi_side = ph;
                lo_side = ~ph;
            end
        endcase
    end

    assign {w_p, v_p, u_p} = enable ? hi_side : 3'b000;
    assign {w_n, v_n, u_n} = enable ? lo_side : 3'b000;

endmodule

`default_nettype wire

//--- verilog/bldc_drive.sv
`timescale 1ns/1ns
`default_nettype none

module bldc_drive #(
    parameter int                 fb_shift    = 4,
    parameter int                 carrier_div = 9,
    parameter pwm_pkg::pwm_mode_e gate_mode   = pwm_pkg::pwm_complementary
) (
    input  wire                            clk,
    input  wire                            arst_n,
    input  wire                            enable,
    input  wire motor_pkg::drive_mode_e    mode,
    input  wire signed [15:0]              velocity,
    input  wire signed [7:0]               offset,
    input  wire [15:0]                     feedback,
    output logic [pwm_pkg::duty_w-1:0]     duty_u,
    output logic [pwm_pkg::duty_w-1:0]     duty_v,
    output logic [pwm_pkg::duty_w-1:0]     duty_w,
    output logic                           duty_strobe,
    output logic                           en,
    output logic                           u_p,
    output logic                           v_p,
    output logic                           w_p,
    output logic                           u_n,
    output logic                           v_n,
    output logic                           w_n
);

    logic [motor_pkg::angle_w-1:0] idx_u;
    logic [motor_pkg::angle_w-1:0] idx_v;
    logic [motor_pkg::angle_w-1:0] idx_w;
    logic [7:0]                    volt;
    logic [7:0]                    mul_a;
    logic [7:0]                    mul_b;
    logic                          mul_req;
    logic [15:0]                   mul_prod;
    logic                          mul_ack;
    logic                          ph_u;
    logic                          ph_v;
    logic                          ph_w;

    assign en = enable;

    phase_angle #(.fb_shift(fb_shift)) phase_angle_i (
        .clk(clk), .arst_n(arst_n), .mode(mode), .velocity(velocity), .offset(offset),
        .feedback(feedback), .idx_u(idx_u), .idx_v(idx_v), .idx_w(idx_w), .volt(volt)
    );

    duty_sequencer duty_sequencer_i (
        .clk(clk), .arst_n(arst_n), .idx_u(idx_u), .idx_v(idx_v), .idx_w(idx_w),
        .volt(volt), .mul_prod(mul_prod), .mul_ack(mul_ack), .mul_a(mul_a), .mul_b(mul_b),
        .mul_req(mul_req), .duty_u(duty_u), .duty_v(duty_v), .duty_w(duty_w),
        .duty_strobe(duty_strobe)
    );

    shift_add_multiplier shift_add_multiplier_i (
        .clk(clk), .arst_n(arst_n), .a(mul_a), .b(mul_b), .req(mul_req),
        .prod(mul_prod), .ack(mul_ack)
    );

    pwm_modulator #(.carrier_div(carrier_div)) pwm_modulator_i (
        .clk(clk), .arst_n(arst_n), .duty_u(duty_u), .duty_v(duty_v), .duty_w(duty_w),
        .ph_u(ph_u), .ph_v(ph_v), .ph_w(ph_w)
    );

    gate_driver #(.gate_mode(gate_mode)) gate_driver_i (
        .enable(enable), .ph_u(ph_u), .ph_v(ph_v), .ph_w(ph_w),
        .idx_u(idx_u), .idx_v(idx_v), .idx_w(idx_w),
        .u_p(u_p), .v_p(v_p), .w_p(w_p), .u_n(u_n), .v_n(v_n), .w_n(w_n)
    );

endmodule

`default_nettype wire

//--- verification/bldc_drive_chk.sv
`timescale 1ns/1ns
`default_nettype none

module bldc_drive_chk #(
    parameter pwm_pkg::pwm_mode_e gate_mode = pwm_pkg::pwm_complementary
) (
    input wire clk,
    input wire arst_n,
    input wire req,
    input wire ack,
    input wire enable,
    input wire u_p,
    input wire v_p,
    input wire w_p,
    input wire u_n,
    input wire v_n,
    input wire w_n
);

    // four-phase handshake
    req_holds: assert property (@(posedge clk) disable iff (!arst_n) req && !ack |=> req)
        else $error("req fell before ack");

    ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n) $rose(ack) |-> req)
        else $error("ack rose without req");

    no_shoot_through: assert property (@(posedge clk) disable iff (!arst_n)
        (gate_mode != pwm_pkg::pwm_complementary) || !(u_p && u_n))
        else $error("u_p and u_n high together");

    gates_off: assert property (@(posedge clk) disable iff (!arst_n)
        !enable |-> !(u_p || v_p || w_p || u_n || v_n || w_n))
        else $error("gate high while enable is low");

endmodule

bind bldc_drive bldc_drive_chk #(.gate_mode(gate_mode)) bldc_drive_chk_i (
    .clk(clk), .arst_n(arst_n), .req(mul_req), .ack(mul_ack), .enable(enable),
    .u_p(u_p), .v_p(v_p), .w_p(w_p), .u_n(u_n), .v_n(v_n), .w_n(w_n)
);

`default_nettype wire

//--- verification/bldc_drive_tb.sv
`timescale 1ns/1ns
`default_nettype none

module bldc_drive_tb;

    localparam int fb_shift    = 4;
    localparam int carrier_div = 9;
    localparam int pwm_period  = 255 * (carrier_div + 1);
    localparam int max_rows    = 12;
    localparam int cycle_limit = max_rows * 200 + 4 * pwm_period;

    logic                   clk;
    logic                   arst_n;
    logic                   enable;
    motor_pkg::drive_mode_e mode;
    logic signed [15:0]     velocity;
    logic signed [7:0]      offset;
    logic [15:0]            feedback;
    wire [7:0]              duty_u;
    wire [7:0]              duty_v;
    wire [7:0]              duty_w;
    wire                    duty_strobe;
    wire                    en;
    wire                    u_p;
    wire                    v_p;
    wire                    w_p;
    wire                    u_n;
    wire                    v_n;
    wire                    w_n;

    // stimulus columns followed by the expected lead and clipped volt
    motor_pkg::drive_mode_e t_mode [max_rows];
    int                     t_vel  [max_rows];
    int                     t_off  [max_rows];
    int                     t_fb   [max_rows]; // -1 means lfsr feedback
    logic                   t_en   [max_rows];
    int                     t_kind [max_rows]; // 0 duties, 1 fb sweep, 2 pwm count, 3 disabled
    int                     t_lead [max_rows];
    int                     t_volt [max_rows];

    int          n_rows = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          r;
    int          row_err;
    int          hi_cnt;
    int          strobes;
    int          first_round;
    logic [15:0] fb;
    logic [15:0] lfsr;

    bldc_drive bldc_drive_i (
        .clk(clk), .arst_n(arst_n), .enable(enable), .mode(mode), .velocity(velocity),
        .offset(offset), .feedback(feedback), .duty_u(duty_u), .duty_v(duty_v),
        .duty_w(duty_w), .duty_strobe(duty_strobe), .en(en),
        .u_p(u_p), .v_p(v_p), .w_p(w_p), .u_n(u_n), .v_n(v_n), .w_n(w_n)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped producing rounds", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic add_row(input motor_pkg::drive_mode_e m, input int vel, input int off,
                           input int fbv, input logic e, input int kind, input int lead,
                           input int volt);
        t_mode[n_rows] = m;
        t_vel[n_rows]  = vel;
        t_off[n_rows]  = off;
        t_fb[n_rows]   = fbv;
        t_en[n_rows]   = e;
        t_kind[n_rows] = kind;
        t_lead[n_rows] = lead;
        t_volt[n_rows] = volt;
        n_rows++;
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fbit;
        fbit = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fbit};
    endfunction

    task automatic random_word(output logic [15:0] w);
        w = '0;
        repeat (16) begin
            lfsr = lfsr_next(lfsr);
            w    = {w[14:0], lfsr[0]};
        end
    endtask

    function automatic int expected_duty(input int row, input logic [15:0] fbv,
                                         input int spacing);
        int         base;
        logic [5:0] idx;
        if (t_mode[row] == motor_pkg::drive_test) base = t_off[row];
        else base = int'(fbv >> fb_shift) + t_off[row] + t_lead[row];
        idx = 6'((base + spacing) & 63); // wraps negative angles too
        return int'(motor_pkg::sine_value(idx)) * t_volt[row] / 100;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_strobes(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(negedge clk);
            if (duty_strobe) seen++;
        end
    endtask

    task automatic check_duties(input int row, input logic [15:0] fbv);
        check_value("duty_u", duty_u, expected_duty(row, fbv, 0));
        check_value("duty_v", duty_v, expected_duty(row, fbv, motor_pkg::phase_v_offset));
        check_value("duty_w", duty_w, expected_duty(row, fbv, motor_pkg::phase_w_offset));
    endtask

    initial begin
        arst_n   = 1'b0;
        enable   = 1'b0;
        mode     = motor_pkg::drive_run;
        velocity = '0;
        offset   = '0;
        feedback = '0;
        lfsr     = 16'd31354;

        add_row(motor_pkg::drive_run, 50, 0, 16'h0100, 1'b1, 0, 16, 50);
        add_row(motor_pkg::drive_run, -75, 5, 16'h0230, 1'b1, 0, -16, 75);
        add_row(motor_pkg::drive_run, 0, 3, 16'h0150, 1'b1, 0, 0, 0);
        add_row(motor_pkg::drive_run, 300, 0, 16'h03f0, 1'b1, 0, 16, 100);    // clip, wrap past 63
        add_row(motor_pkg::drive_run, -1000, -10, 16'h0020, 1'b1, 0, -16, 100);
        add_row(motor_pkg::drive_calibrate, 80, 7, 16'h0200, 1'b1, 0, 0, 80);
        add_row(motor_pkg::drive_test, 60, 20, 16'h0111, 1'b1, 1, 0, 60);
        add_row(motor_pkg::drive_test, -90, -3, 16'h0000, 1'b1, 1, 0, 90);
        add_row(motor_pkg::drive_run, 70, -8, 16'h0000, 1'b1, 2, 16, 70);
        add_row(motor_pkg::drive_run, 40, 12, 16'h0180, 1'b0, 3, 16, 40);
        add_row(motor_pkg::drive_run, 65, 9, -1, 1'b1, 0, 16, 65);
        add_row(motor_pkg::drive_run, -30, -40, -1, 1'b1, 0, -16, 30);

        repeat (5) begin
            @(negedge clk);
            check_value("duty_u", duty_u, 0);
            check_value("duty_v", duty_v, 0);
            check_value("duty_w", duty_w, 0);
            check_value("duty_strobe", duty_strobe, 0);
            check_value("gates", {u_p, v_p, w_p, u_n, v_n, w_n}, 0);
        end
        @(posedge clk);
        #2 arst_n = 1'b1;
        first_round = 0;
        do begin
            @(negedge clk);
            first_round++;
            check_value("gates", {u_p, v_p, w_p, u_n, v_n, w_n}, 0);
            if (!duty_strobe) check_value("duty_u", duty_u, 0);
        end while (!duty_strobe);
        // three multiplies of at least req plus 9 clocks each
        checks++;
        if (first_round < 30) begin
            $display("duty_strobe rose %0d clocks after reset, before three multiplies",
                     first_round);
            errors++;
        end
        $display("test 0 reset: %0d errors", errors);

        for (r = 0; r < n_rows; r++) begin
            row_err = errors;
            if (t_fb[r] < 0) random_word(fb);
            else fb = 16'(t_fb[r]);
            @(posedge clk);
            #2;
            mode     = t_mode[r];
            velocity = 16'(t_vel[r]);
            offset   = 8'(t_off[r]);
            feedback = fb;
            enable   = t_en[r];
            wait_strobes(2);
            check_duties(r, fb);
            check_value("en", en, t_en[r]);
            case (t_kind[r])
                1: begin
                    @(posedge clk);
                    #2 feedback = ~fb;
                    wait_strobes(2);
                    check_duties(r, ~fb);
                end
                2: begin
                    hi_cnt = 0;
                    repeat (pwm_period) begin
                        @(negedge clk);
                        if (u_p) hi_cnt++;
                        check_value("u_n", u_n, !u_p);
                    end
                    checks++;
                    if (hi_cnt < (expected_duty(r, fb, 0) - 1) * (carrier_div + 1) ||
                        hi_cnt > (expected_duty(r, fb, 0) + 1) * (carrier_div + 1)) begin
                        $display("MISMATCH t=%0t u_p_high_clocks got %0d expected %0d", $time,
                                 hi_cnt, expected_duty(r, fb, 0) * (carrier_div + 1));
                        errors++;
                    end
                end
                3: begin
                    strobes = 0;
                    repeat (pwm_period) begin
                        @(negedge clk);
                        check_value("gates", {u_p, v_p, w_p, u_n, v_n, w_n}, 0);
                        if (duty_strobe) strobes++;
                    end
                    checks++;
                    if (strobes == 0) begin
                        $display("duties stopped updating while the gates were disabled");
                        errors++;
                    end
                end
                default: ;
            endcase
            $display("test %0d %s: %0d errors", r + 1, (errors == row_err) ? "ok" : "FAILED",
                     errors - row_err);
        end

        $display("tests %0d, checks %0d, errors %0d", n_rows + 1, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
common/motor_pkg.sv
common/pwm_pkg.sv
commutation/phase_angle.sv
commutation/duty_sequencer.sv
verilog/shift_add_multiplier.sv
pwm/pwm_modulator.sv
pwm/gate_driver.sv
verilog/bldc_drive.sv
verification/bldc_drive_chk.sv
verification/bldc_drive_tb.sv
